/* filelist.f */
+incdir+include
verilog/fetch_bus_pkg.sv
verilog/instr_align_pkg.sv
verilog/fetch_request_ctrl.sv
verilog/resp_fifo.sv
verilog/instr_aligner.sv
verilog/align_buffer_top.sv
verif/tb_align_buffer.sv

/* include/align_config.svh */
// Alignment buffer configuration
`ifndef ALIGN_CONFIG_SVH
`define ALIGN_CONFIG_SVH

// Width of instruction and fetch addresses
`define ALIGN_ADDR_W 32

// Width of one fetched word
`define ALIGN_WORD_W 32

// Response words held in the FIFO
// Three is the least that lets a split instruction wait for its second word
`define ALIGN_FIFO_DEPTH 3

// Fetches allowed in flight at once
// Together with the depth above this keeps the FIFO from overflowing
`define ALIGN_MAX_OUTSTANDING 2

`endif

/* run.sh */
#!/usr/bin/env bash
# Build and run the alignment buffer testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f filelist.f \
  --top-module tb_align_buffer \
  -o sim_align

./obj_dir/sim_align | tee sim.log

if grep -q "^RESULT: PASS$" sim.log; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed"
  exit 1
fi

/* verif/align_golden.txt */
# M <word address> <data> <err>, B <instructions emitted> <target>
# E <address> <instruction> <err>, expected transfers in order
# Block A, mixed code with two split instructions
M 00000100 45854501 0
M 00000104 00a00093 0
M 00000108 01134605 0
M 0000010c 80820020 0
M 00000110 00300193 0
M 00000114 02130001 0
M 00000118 46810040 0
M 0000011c 00500293 0
# Block B, odd target with dead low half and an error word
M 00000200 47050073 0
M 00000204 03934785 0
M 00000208 48010060 1
M 0000020c 00700413 0
# Block C, aligned target with errors in first words
M 00000300 00800493 1
M 00000304 00900513 0
M 00000308 05934881 1
M 0000030c 48a100a0 0
M 00000310 00b00613 0
# Branches
B 0 00000100
B 11 00000202
B 16 00000300
B 22 0000010a
# Expected stream
E 00000100 00004501 0
E 00000102 00004585 0
E 00000104 00a00093 0
E 00000108 00004605 0
E 0000010a 00200113 0
E 0000010e 00008082 0
E 00000110 00300193 0
E 00000114 00000001 0
E 00000116 00400213 0
E 0000011a 00004681 0
E 0000011c 00500293 0
E 00000202 00004705 0
E 00000204 00004785 0
E 00000206 00600393 1
E 0000020a 00004801 1
E 0000020c 00700413 0
E 00000300 00800493 1
E 00000304 00900513 0
E 00000308 00004881 1
E 0000030a 00a00593 1
E 0000030e 000048a1 0
E 00000310 00b00613 0
E 0000010a 00200113 0
E 0000010e 00008082 0
E 00000110 00300193 0
E 00000114 00000001 0
E 00000116 00400213 0
E 0000011a 00004681 0
E 0000011c 00500293 0

/* verif/tb_align_buffer.sv */
// Alignment buffer testbench
`timescale 1ns/10ps
`include "align_config.svh"

module tb_align_buffer
  import fetch_bus_pkg::*;
  import instr_align_pkg::*;
();

  //////////////////////////////////////////////////////////////////////
  // DUT signals and testbench state
  //////////////////////////////////////////////////////////////////////

  logic                     clk;
  logic                     rst_n;
  align_ctrl_t              ctrl;
  logic [`ALIGN_ADDR_W-1:0] branch_addr;
  logic                     fetch_valid, fetch_ready;
  branch_req_t              branch;
  logic                     resp_valid;
  fetch_resp_t              resp;
  logic                     instr_valid, instr_ready;
  instr_out_t               instr;
  logic                     busy;

  // Memory image and golden stream
  logic [31:0] mem_data [logic [31:0]];
  logic        mem_err  [logic [31:0]];
  int          br_count[$];
  logic [31:0] br_target[$];
  logic [31:0] exp_addr[$];
  logic [31:0] exp_instr[$];
  logic        exp_err[$];

  // Fetches accepted but not yet answered, with the cycle they are due
  logic [31:0] pend_addr[$];
  int          pend_due[$];
  logic [31:0] next_fetch;

  int          cycle, emitted, exp_idx, br_idx, checks, errors;
  logic        started, loaded;
  logic        hold_pending;
  instr_out_t  held_instr;

  align_buffer_top dut (
    .clk             (clk),
    .rst_n           (rst_n),
    .ctrl_i          (ctrl),
    .branch_addr_i   (branch_addr),
    .fetch_valid_o   (fetch_valid),
    .fetch_ready_i   (fetch_ready),
    .branch_o        (branch),
    .resp_valid_i    (resp_valid),
    .resp_i          (resp),
    .instr_valid_o   (instr_valid),
    .instr_ready_i   (instr_ready),
    .instr_o         (instr),
    .prefetch_busy_o (busy)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, got, exp);
      errors++;
    end
  endtask

  // Words outside the image get a pattern built from the address
  function automatic fetch_resp_t mem_read(input logic [31:0] addr);
    fetch_resp_t r;
    r.rdata = addr ^ 32'ha5a5_5a5a;
    r.err   = 1'b0;
    if (mem_data.exists(addr)) begin
      r.rdata = mem_data[addr];
      r.err   = mem_err[addr];
    end
    return r;
  endfunction

  task automatic load_golden();
    int                 fd;
    int                 code;
    int                 cnt;
    string              tag;
    logic [8*128-1:0]   rest;
    logic [31:0]        a, d, e;
    fd = $fopen("verif/align_golden.txt", "r");
    if (fd == 0) begin
      $display("Could not open the golden data file");
      errors++;
      return;
    end
    while (!$feof(fd)) begin
      code = $fscanf(fd, "%s", tag);
      if (code != 1) break;
      if (tag == "#") begin
        code = $fgets(rest, fd);
      end else if (tag == "M") begin
        code = $fscanf(fd, "%h %h %h", a, d, e);
        mem_data[a] = d;
        mem_err[a]  = e[0];
      end else if (tag == "B") begin
        code = $fscanf(fd, "%d %h", cnt, a);
        br_count.push_back(cnt);
        br_target.push_back(a);
      end else if (tag == "E") begin
        code = $fscanf(fd, "%h %h %h", a, d, e);
        exp_addr.push_back(a);
        exp_instr.push_back(d);
        exp_err.push_back(e[0]);
      end else begin
        $display("Unknown record in golden data file");
        errors++;
      end
    end
    $fclose(fd);
  endtask

  task automatic finish_run();
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Stimulus on the falling edge
  //////////////////////////////////////////////////////////////////////

  always @(negedge clk) begin
    if (started) begin
      fetch_ready    = ($urandom % 4) != 0;
      instr_ready    = ($urandom % 3) != 0;
      // Requests stop once the whole golden stream was seen
      ctrl.instr_req = exp_idx < exp_addr.size();
      ctrl.pc_set    = 1'b0;
      ctrl.kill_if   = 1'b0;
      if (ctrl.instr_req && (br_idx < br_count.size()) && (emitted == br_count[br_idx])) begin
        ctrl.pc_set  = 1'b1;
        ctrl.kill_if = 1'b1;
        branch_addr  = br_target[br_idx];
        br_idx++;
      end
    end
    // In order, one word per cycle once its latency has passed
    if ((pend_addr.size() != 0) && (pend_due[0] <= cycle)) begin
      resp_valid = 1'b1;
      resp       = mem_read(pend_addr.pop_front());
      pend_due.delete(0);
    end else begin
      resp_valid = 1'b0;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Memory model and output checks on the rising edge
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    if (rst_n) begin
      cycle++;
      // Branch goes to the prefetcher as the word holding the target
      if (ctrl.pc_set) begin
        check_value("branch_o.branch", {31'b0, branch.branch}, 32'd1);
        check_value("branch_o.addr", branch.addr, branch_addr & 32'hffff_fffc);
      end
      // Prefetcher restarts at the word holding the target
      if (branch.branch) begin
        next_fetch = branch.addr;
      end
      if (fetch_valid && fetch_ready) begin
        pend_addr.push_back(next_fetch);
        pend_due.push_back(cycle + int'($urandom % 3));
        next_fetch = next_fetch + 32'd4;
        assert (pend_addr.size() <= `ALIGN_MAX_OUTSTANDING) else begin
          $display("More than two fetches left unanswered by the memory model");
          errors++;
        end
      end
      // Held instruction must not move while the IF stage stalls
      if (hold_pending && !ctrl.kill_if) begin
        assert (instr_valid) else begin
          $display("Instruction valid dropped while stalled");
          errors++;
        end
        check_value("instr_o.instr (stalled)", instr.instr, held_instr.instr);
        check_value("instr_o.addr (stalled)", instr.addr, held_instr.addr);
        check_value("instr_o.err (stalled)", {31'b0, instr.err}, {31'b0, held_instr.err});
      end
      hold_pending = instr_valid && !instr_ready;
      held_instr   = instr;
      if (instr_valid && instr_ready) begin
        if (exp_idx < exp_addr.size()) begin
          check_value("instr_o.addr", instr.addr, exp_addr[exp_idx]);
          check_value("instr_o.instr", instr.instr, exp_instr[exp_idx]);
          check_value("instr_o.err", {31'b0, instr.err}, {31'b0, exp_err[exp_idx]});
          exp_idx++;
        end
        emitted++;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Sequence and watchdog
  //////////////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(32'hb0d5_1d5b));
    rst_n        = 1'b0;
    ctrl         = '0;
    branch_addr  = '0;
    fetch_ready  = 1'b0;
    resp_valid   = 1'b0;
    resp         = '0;
    instr_ready  = 1'b0;
    next_fetch   = '0;
    started      = 1'b0;
    loaded       = 1'b0;
    hold_pending = 1'b0;
    load_golden();
    loaded = 1'b1;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    // Idle after reset until the controller asks for fetches
    repeat (3) begin
      @(posedge clk);
      assert (!fetch_valid && !busy && !instr_valid && !branch.branch) else begin
        $display("Outputs active before any fetch was requested");
        errors++;
      end
    end
    if (exp_addr.size() == 0) begin
      $display("No expected instructions in the golden data file");
      errors++;
    end else begin
      started = 1'b1;
      wait (exp_idx == exp_addr.size());
      @(posedge clk);
      while (busy || (pend_addr.size() != 0)) @(posedge clk);
    end
    finish_run();
  end

  initial begin
    wait (loaded);
    repeat (200 * (exp_addr.size() + 1)) @(posedge clk);
    $display("Timeout, the instruction stream did not complete in time");
    errors++;
    finish_run();
  end

endmodule

/* verilog/align_buffer_top.sv */
// Alignment buffer top level
`timescale 1ns/10ps
`include "align_config.svh"

module align_buffer_top
  import fetch_bus_pkg::*;
  import instr_align_pkg::*;
(
  input  logic                     clk,
  input  logic                     rst_n,
  // Controller
  input  align_ctrl_t              ctrl_i,
  input  logic [`ALIGN_ADDR_W-1:0] branch_addr_i,
  // Prefetcher
  output logic                     fetch_valid_o,
  input  logic                     fetch_ready_i,
  output branch_req_t              branch_o,
  // Response bus
  input  logic                     resp_valid_i,
  input  fetch_resp_t              resp_i,
  // IF stage
  output logic                     instr_valid_o,
  input  logic                     instr_ready_i,
  output instr_out_t               instr_o,
  output logic                     prefetch_busy_o
);

  //////////////////////////////////////////////////////////////////////
  // Internal wires
  //////////////////////////////////////////////////////////////////////

  logic        resp_accept;
  fetch_resp_t head, next;
  logic        head_valid, next_valid, head_stored;
  logic        advance, free_head, emit;

  // Request side with flush filtering
  fetch_request_ctrl u_req (
    .clk             (clk),
    .rst_n           (rst_n),
    .ctrl_i          (ctrl_i),
    .branch_addr_i   (branch_addr_i),
    .fetch_valid_o   (fetch_valid_o),
    .fetch_ready_i   (fetch_ready_i),
    .branch_o        (branch_o),
    .prefetch_busy_o (prefetch_busy_o),
    .resp_valid_i    (resp_valid_i),
    .resp_i          (resp_i),
    .resp_accept_o   (resp_accept),
    .emit_i          (emit)
  );

  // Word store
  resp_fifo u_fifo (
    .clk           (clk),
    .rst_n         (rst_n),
    .kill_i        (ctrl_i.kill_if),
    .resp_accept_i (resp_accept),
    .resp_i        (resp_i),
    .advance_i     (advance),
    .free_head_i   (free_head),
    .head_o        (head),
    .next_o        (next),
    .head_valid_o  (head_valid),
    .next_valid_o  (next_valid),
    .head_stored_o (head_stored)
  );

  // Output side
  instr_aligner u_align (
    .clk           (clk),
    .rst_n         (rst_n),
    .ctrl_i        (ctrl_i),
    .branch_addr_i (branch_addr_i),
    .head_i        (head),
    .next_i        (next),
    .head_valid_i  (head_valid),
    .next_valid_i  (next_valid),
    .head_stored_i (head_stored),
    .instr_valid_o (instr_valid_o),
    .instr_ready_i (instr_ready_i),
    .instr_o       (instr_o),
    .advance_o     (advance),
    .free_head_o   (free_head),
    .emit_o        (emit)
  );

endmodule

/* verilog/fetch_bus_pkg.sv */
// Fetch bus types
`include "align_config.svh"

package fetch_bus_pkg;

  //////////////////////////////////////////////////////////////////////
  // Response side of the fetch bus
  //////////////////////////////////////////////////////////////////////

  // One word returned by memory, in request order
  typedef struct packed {
    logic [`ALIGN_WORD_W-1:0] rdata;
    // Bus error for the whole word
    logic                     err;
  } fetch_resp_t;

  //////////////////////////////////////////////////////////////////////
  // Request side of the fetch bus
  //////////////////////////////////////////////////////////////////////

  // Branch indication to the prefetcher
  typedef struct packed {
    // Set for the fetch that starts a new stream
    logic                     branch;
    // Word aligned target, low two bits always zero
    logic [`ALIGN_ADDR_W-1:0] addr;
  } branch_req_t;

endpackage

/* verilog/fetch_request_ctrl.sv */
// Fetch request control
`timescale 1ns/10ps
`include "align_config.svh"

module fetch_request_ctrl
  import fetch_bus_pkg::*;
  import instr_align_pkg::*;
(
  input  logic                     clk,
  input  logic                     rst_n,
  // Controller command and branch target
  input  align_ctrl_t              ctrl_i,
  input  logic [`ALIGN_ADDR_W-1:0] branch_addr_i,
  // Prefetcher handshake
  output logic                     fetch_valid_o,
  input  logic                     fetch_ready_i,
  output branch_req_t              branch_o,
  output logic                     prefetch_busy_o,
  // Response bus
  input  logic                     resp_valid_i,
  input  fetch_resp_t              resp_i,
  output logic                     resp_accept_o,
  // Transfer pulse from the aligner, already one cycle late
  input  logic                     emit_i
);

  localparam int unsigned MAX_OUT = `ALIGN_MAX_OUTSTANDING;
  localparam int unsigned OUT_W   = $clog2(MAX_OUT + 1);
  // Two instructions per word at most
  localparam int unsigned CNT_W   = $clog2(2 * `ALIGN_FIFO_DEPTH + 1);

  // Fetches in flight and stale responses still to drop
  logic [OUT_W-1:0] out_cnt_q, out_cnt_n;
  logic [OUT_W-1:0] flush_q, flush_n, flush_branch;

  // Complete instructions sitting in the FIFO
  logic [CNT_W-1:0] instr_cnt_q, instr_cnt_n, instr_cnt_adj;

  // Write side position within the instruction stream
  logic             aligned_q, aligned_n;
  logic             complete_q, complete_n;
  logic [1:0]       n_incoming;
  logic             lo_compressed, hi_compressed;
  logic             fetch_accept;

  //////////////////////////////////////////////////////////////////////
  // Request decision
  //////////////////////////////////////////////////////////////////////

  assign instr_cnt_adj = instr_cnt_q - CNT_W'(emit_i);

  // Refill when the buffer runs dry, or early when nothing is in flight
  // A branch always fetches, subject only to the outstanding limit
  assign fetch_valid_o = ctrl_i.instr_req && (out_cnt_q < OUT_W'(MAX_OUT)) &&
                         ((instr_cnt_adj == '0) ||
                          ((instr_cnt_adj == CNT_W'(1)) && (out_cnt_q == '0)) ||
                          ctrl_i.pc_set);

  assign fetch_accept    = fetch_valid_o && fetch_ready_i;
  assign prefetch_busy_o = (out_cnt_q != '0) || fetch_valid_o;

  // Prefetcher only ever sees word addresses
  assign branch_o.branch = ctrl_i.pc_set;
  assign branch_o.addr   = {branch_addr_i[`ALIGN_ADDR_W-1:2], 2'b00};

  // Responses owed to an old stream are swallowed here
  assign resp_accept_o = resp_valid_i && (flush_q == '0);

  //////////////////////////////////////////////////////////////////////
  // Counters
  //////////////////////////////////////////////////////////////////////

  assign out_cnt_n = out_cnt_q + OUT_W'(fetch_accept) - OUT_W'(resp_valid_i);

  // Everything in flight is stale except a response landing right now
  assign flush_branch = out_cnt_q - OUT_W'(resp_valid_i);

  always_comb begin
    flush_n = flush_q;
    if (ctrl_i.pc_set) begin
      flush_n = flush_branch;
    end else if (resp_valid_i && (flush_q != '0)) begin
      flush_n = flush_q - OUT_W'(1);
    end
  end

  assign lo_compressed = is_compressed(resp_i.rdata[15:0]);
  assign hi_compressed = is_compressed(resp_i.rdata[31:16]);

  // Count whole instructions per accepted word
  always_comb begin
    aligned_n  = aligned_q;
    complete_n = complete_q;
    n_incoming = 2'd0;
    if (ctrl_i.pc_set) begin
      // Unaligned and complete marks an odd target with a dead low half
      aligned_n  = !branch_addr_i[1];
      complete_n = branch_addr_i[1];
    end else if (resp_accept_o) begin
      if (aligned_q && !lo_compressed) begin
        // Single 32-bit instruction, position unchanged
        n_incoming = 2'd1;
      end else begin
        // Low half ends an instruction unless it is the dead half
        n_incoming = (aligned_q || !complete_q) ? 2'd1 : 2'd0;
        if (hi_compressed) begin
          n_incoming = n_incoming + 2'd1;
          aligned_n  = 1'b1;
          complete_n = 1'b1;
        end else begin
          // Upper half starts a split instruction
          aligned_n  = 1'b0;
          complete_n = 1'b0;
        end
      end
    end
  end

  // Emits are subtracted one cycle late
  assign instr_cnt_n = ctrl_i.kill_if ? '0 :
                       instr_cnt_q + CNT_W'(n_incoming) - CNT_W'(emit_i);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_cnt_q   <= '0;
      flush_q     <= '0;
      instr_cnt_q <= '0;
      aligned_q   <= 1'b1;
      complete_q  <= 1'b1;
    end else begin
      out_cnt_q   <= out_cnt_n;
      flush_q     <= flush_n;
      instr_cnt_q <= instr_cnt_n;
      aligned_q   <= aligned_n;
      complete_q  <= complete_n;
    end
  end

  // The bus must never carry more fetches than the FIFO can absorb
  a_outstanding_limit: assert property (@(posedge clk) disable iff (!rst_n)
    out_cnt_q <= OUT_W'(MAX_OUT))
    else $error("outstanding fetch count above limit");

endmodule

/* verilog/instr_align_pkg.sv */
// Instruction side types
`include "align_config.svh"

package instr_align_pkg;

  //////////////////////////////////////////////////////////////////////
  // Controller interface
  //////////////////////////////////////////////////////////////////////

  // Command from the core controller
  // pc_set and kill_if come together on a branch
  typedef struct packed {
    logic instr_req;
    logic pc_set;
    logic kill_if;
  } align_ctrl_t;

  // Instruction handed to the IF stage
  typedef struct packed {
    // Compressed instructions sit zero extended in the low half
    logic [`ALIGN_WORD_W-1:0] instr;
    logic                     err;
    logic [`ALIGN_ADDR_W-1:0] addr;
  } instr_out_t;

  // Index into the response FIFO
  typedef logic [$clog2(`ALIGN_FIFO_DEPTH)-1:0] fifo_ptr_t;

  //////////////////////////////////////////////////////////////////////
  // Decode helpers
  //////////////////////////////////////////////////////////////////////

  // RVC encoding uses every opcode quadrant except 2'b11
  function automatic logic is_compressed(input logic [15:0] halfword);
    return halfword[1:0] != 2'b11;
  endfunction

endpackage

/* verilog/instr_aligner.sv */
// Instruction aligner
`timescale 1ns/10ps
`include "align_config.svh"

module instr_aligner
  import fetch_bus_pkg::*;
  import instr_align_pkg::*;
(
  input  logic                     clk,
  input  logic                     rst_n,
  input  align_ctrl_t              ctrl_i,
  input  logic [`ALIGN_ADDR_W-1:0] branch_addr_i,
  // Words presented by the FIFO
  input  fetch_resp_t              head_i,
  input  fetch_resp_t              next_i,
  input  logic                     head_valid_i,
  input  logic                     next_valid_i,
  input  logic                     head_stored_i,
  // IF stage handshake
  output logic                     instr_valid_o,
  input  logic                     instr_ready_i,
  output instr_out_t               instr_o,
  // FIFO read control
  output logic                     advance_o,
  output logic                     free_head_o,
  // Delayed transfer pulse for the request side
  output logic                     emit_o
);

  localparam int unsigned AW = `ALIGN_ADDR_W;

  logic [AW-1:0] addr_q, addr_n, addr_incr;
  logic          odd;
  logic          head_lo_c, head_hi_c;
  logic          split_valid;
  logic          transfer;
  logic          emit_q;

  assign odd       = addr_q[1];
  assign head_lo_c = is_compressed(head_i.rdata[15:0]);
  assign head_hi_c = is_compressed(head_i.rdata[31:16]);

  // Second word of a split is only real behind a stored head
  // With an empty FIFO the bus word is the head itself
  assign split_valid = head_stored_i && next_valid_i;

  //////////////////////////////////////////////////////////////////////
  // Output selection
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    instr_o.addr  = addr_q;
    instr_o.err   = head_i.err;
    instr_valid_o = head_valid_i;
    if (!odd) begin
      instr_o.instr = head_lo_c ? {16'h0000, head_i.rdata[15:0]} : head_i.rdata;
    end else if (head_hi_c) begin
      instr_o.instr = {16'h0000, head_i.rdata[31:16]};
    end else begin
      // Split instruction, upper half of head then low half of next
      instr_o.instr = {next_i.rdata[15:0], head_i.rdata[31:16]};
      instr_o.err   = head_i.err | next_i.err;
      instr_valid_o = split_valid;
    end
    // Nothing leaves while the stream is being flushed
    if (ctrl_i.kill_if) begin
      instr_valid_o = 1'b0;
    end
  end

  assign transfer = instr_valid_o && instr_ready_i;

  // Head word is used up unless a compressed instruction took its low half
  assign free_head_o = odd || !head_lo_c;
  assign advance_o   = transfer;
  assign emit_o      = emit_q;

  //////////////////////////////////////////////////////////////////////
  // Address tracking
  //////////////////////////////////////////////////////////////////////

  assign addr_incr = {addr_q[AW-1:2], 2'b00} + AW'(4);

  always_comb begin
    if (odd) begin
      // An odd uncompressed one ends in the next word at its upper half
      addr_n = head_hi_c ? addr_incr : {addr_incr[AW-1:2], 2'b10};
    end else begin
      addr_n = head_lo_c ? {addr_q[AW-1:2], 2'b10} : addr_incr;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      addr_q <= '0;
      emit_q <= 1'b0;
    end else begin
      if (ctrl_i.pc_set) begin
        addr_q <= branch_addr_i;
      end else if (transfer) begin
        addr_q <= addr_n;
      end
      emit_q <= transfer;
    end
  end

  // Kill blanks the output and the FIFO comes back without old words
  a_kill_flush: assert property (@(posedge clk) disable iff (!rst_n)
    ctrl_i.kill_if |-> !instr_valid_o ##1 !head_stored_i)
    else $error("instruction valid during kill or stale word kept after kill");

  // Stalled output holds until taken, which relies on the FIFO keeping its words
  a_stall_stable: assert property (@(posedge clk) disable iff (!rst_n)
    instr_valid_o && !instr_ready_i ##1 !ctrl_i.kill_if |->
      instr_valid_o && $stable(instr_o))
    else $error("instruction changed while stalled");

endmodule

/* verilog/resp_fifo.sv */
// Fetch response FIFO
`timescale 1ns/10ps
`include "align_config.svh"

module resp_fifo
  import fetch_bus_pkg::*;
  import instr_align_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        kill_i,
  // Write side
  input  logic        resp_accept_i,
  input  fetch_resp_t resp_i,
  // Read side control from the aligner
  input  logic        advance_i,
  input  logic        free_head_i,
  // Two oldest words with bypass of the incoming one
  output fetch_resp_t head_o,
  output fetch_resp_t next_o,
  output logic        head_valid_o,
  output logic        next_valid_o,
  // Head comes from storage and not from the bus
  output logic        head_stored_o
);

  localparam int unsigned DEPTH = `ALIGN_FIFO_DEPTH;

  fetch_resp_t      mem_q [DEPTH];
  logic [DEPTH-1:0] valid_q, valid_n;
  fifo_ptr_t        wptr_q, rptr_q, rptr2;
  logic             pop;

  // Wrapping step through a non power of two depth
  function automatic fifo_ptr_t ptr_inc(input fifo_ptr_t ptr);
    return (ptr == fifo_ptr_t'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign rptr2 = ptr_inc(rptr_q);

  // Head word is released once the emitted instruction used all of it
  assign pop = advance_i && free_head_i;

  //////////////////////////////////////////////////////////////////////
  // Valid bits and pointers
  //////////////////////////////////////////////////////////////////////

  // A word passing straight through is set and cleared in one go
  always_comb begin
    valid_n = valid_q;
    if (resp_accept_i) begin
      valid_n[wptr_q] = 1'b1;
    end
    if (pop) begin
      valid_n[rptr_q] = 1'b0;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= '0;
      wptr_q  <= '0;
      rptr_q  <= '0;
    end else if (kill_i) begin
      // Start over empty for the new stream
      valid_q <= '0;
      wptr_q  <= '0;
      rptr_q  <= '0;
    end else begin
      valid_q <= valid_n;
      if (resp_accept_i) begin
        wptr_q <= ptr_inc(wptr_q);
      end
      if (pop) begin
        rptr_q <= rptr2;
      end
    end
  end

  // Storage array
  always_ff @(posedge clk) begin
    if (resp_accept_i && !kill_i) begin
      mem_q[wptr_q] <= resp_i;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Read ports
  //////////////////////////////////////////////////////////////////////

  assign head_stored_o = valid_q[rptr_q];

  // Empty entries show the word on the bus
  assign head_o = valid_q[rptr_q] ? mem_q[rptr_q] : resp_i;
  assign next_o = valid_q[rptr2] ? mem_q[rptr2] : resp_i;

  assign head_valid_o = valid_q[rptr_q] || resp_accept_i;
  assign next_valid_o = valid_q[rptr2] || resp_accept_i;

  // The request limit has to keep a free slot for every accepted word
  a_no_overwrite: assert property (@(posedge clk) disable iff (!rst_n)
    resp_accept_i && !kill_i |-> !valid_q[wptr_q])
    else $error("response written over a valid FIFO entry");

endmodule
